/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mcu_pwr_irq
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/domain_reset_gen.sv */
// ------------------------------
// registered resets for the system,
// cpu and peripheral domains
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module domain_reset_gen (
  input  logic clk_i,
  input  logic reset_i,
  input  logic debug_ndmreset_ni,
  input  logic cpu_seq_rst_ni,
  input  logic periph_seq_rst_ni,
  output logic sys_rst_no,
  output logic cpu_rst_no,
  output logic periph_rst_no
);

  logic sys_rst_n_q;
  logic cpu_rst_n_q;
  logic periph_rst_n_q;

  // every domain held while in reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sys_rst_n_q    <= 1'b0;
      cpu_rst_n_q    <= 1'b0;
      periph_rst_n_q <= 1'b0;
    end else begin
      sys_rst_n_q    <= debug_ndmreset_ni;
      // a domain is also reset by its own power sequence
      cpu_rst_n_q    <= debug_ndmreset_ni & cpu_seq_rst_ni;
      periph_rst_n_q <= debug_ndmreset_ni & periph_seq_rst_ni;
    end
  end

  assign sys_rst_no    = sys_rst_n_q;
  assign cpu_rst_no    = cpu_rst_n_q;
  assign periph_rst_no = periph_rst_n_q;

endmodule

`default_nettype wire

/* design/irq_wakeup_ctrl.sv */
// ------------------------------
// interrupt vector assembly and
// cpu domain power-off request
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module irq_wakeup_ctrl
  import mcu_ctrl_pkg::*;
(
  input  timer_intr_t   timer_intr_i,
  input  logic          dma_done_intr_i,
  input  logic          spi_intr_i,
  input  logic          spi_flash_intr_i,
  input  logic          irq_software_i,
  input  logic          irq_external_i,
  input  gpio_ao_intr_t gpio_ao_intr_i,
  input  logic          core_sleep_i,
  input  logic          cpu_pwr_off_en_i,
  output intr_vec_t     intr_o,
  output fast_intr_t    fast_intr_o,
  output logic          cpu_off_req_o
);

  // fast lines: timers 1..3, dma, spi, spi flash, then the ao gpio
  always_comb begin
    fast_intr_o = '0;
    fast_intr_o[NUM_TIMERS-2:0] = timer_intr_i[NUM_TIMERS-1:1];
    fast_intr_o[3] = dma_done_intr_i;
    fast_intr_o[4] = spi_intr_i;
    fast_intr_o[5] = spi_flash_intr_i;
    fast_intr_o[6 +: GPIO_AO_W] = gpio_ao_intr_i;
  end

  // timer 0 is the standard machine timer line
  always_comb begin
    intr_o = '0;
    intr_o[IRQ_SW_BIT]    = irq_software_i;
    intr_o[IRQ_TIMER_BIT] = timer_intr_i[0];
    intr_o[IRQ_EXT_BIT]   = irq_external_i;
    intr_o[IRQ_FAST_LSB +: FAST_INTR_W] = fast_intr_o;
  end

  // any pending line drops the request in the same cycle,
  // so the sequencer never starts a power-down against a wake-up
  assign cpu_off_req_o = core_sleep_i & cpu_pwr_off_en_i & ~(|intr_o);

endmodule

`default_nettype wire

/* design/mcu_ctrl_pkg.sv */
// ------------------------------
// power and interrupt control: widths,
// interrupt bit positions and sequencer states
// ------------------------------
`default_nettype none

package mcu_ctrl_pkg;

  // vector widths
  localparam int INTR_W      = 32;
  localparam int FAST_INTR_W = 15;
  localparam int GPIO_AO_W   = 8;
  localparam int NUM_BANKS   = 2;
  localparam int NUM_TIMERS  = 4;

  // machine interrupt positions, as in mip/mie
  localparam int IRQ_SW_BIT    = 3;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_EXT_BIT   = 11;
  localparam int IRQ_FAST_LSB  = 16;

  typedef logic [INTR_W-1:0]      intr_vec_t;
  typedef logic [FAST_INTR_W-1:0] fast_intr_t;
  typedef logic [GPIO_AO_W-1:0]   gpio_ao_intr_t;
  typedef logic [NUM_TIMERS-1:0]  timer_intr_t;
  typedef logic [NUM_BANKS-1:0]   bank_mask_t;

  // switched domain sequencer
  typedef enum logic [3:0] {
    PG_ON,
    PG_CLK_OFF,
    PG_ISO_ON,
    PG_RST_ON,
    PG_SW_OFF,
    PG_OFF,
    PG_SW_ON,
    PG_RST_OFF,
    PG_ISO_OFF
  } pwr_gate_state_t;

  // memory bank retention sequencer
  typedef enum logic [1:0] {
    MR_ACTIVE,
    MR_CLK_OFF,
    MR_RETAIN
  } mem_ret_state_t;

endpackage

`default_nettype wire

/* design/mcu_pwr_irq_top.sv */
// ------------------------------
// always-on power and interrupt control
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module mcu_pwr_irq_top
  import mcu_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  timer_intr_t   timer_intr_i,
  input  logic          dma_done_intr_i,
  input  logic          spi_intr_i,
  input  logic          spi_flash_intr_i,
  input  logic          irq_software_i,
  input  logic          irq_external_i,
  input  gpio_ao_intr_t gpio_ao_intr_i,
  input  logic          core_sleep_i,
  input  logic          cpu_pwr_off_en_i,
  input  logic          periph_pwr_off_req_i,
  input  bank_mask_t    mem_retain_req_i,
  input  logic          debug_ndmreset_ni,
  input  logic          cpu_pwrgate_ack_ni,
  input  logic          periph_pwrgate_ack_ni,
  output intr_vec_t     intr_o,
  output fast_intr_t    fast_intr_o,
  output logic          cpu_clkgate_en_no,
  output logic          cpu_iso_no,
  output logic          cpu_pwrgate_switch_no,
  output logic          cpu_rst_no,
  output logic          periph_clkgate_en_no,
  output logic          periph_iso_no,
  output logic          periph_pwrgate_switch_no,
  output logic          periph_rst_no,
  output logic          sys_rst_no,
  output bank_mask_t    mem_clkgate_en_no,
  output bank_mask_t    mem_set_retentive_no
);

  logic cpu_off_req;
  logic cpu_seq_rst_n;
  logic periph_seq_rst_n;

  irq_wakeup_ctrl irq_ctrl (
    .timer_intr_i, .dma_done_intr_i, .spi_intr_i, .spi_flash_intr_i,
    .irq_software_i, .irq_external_i, .gpio_ao_intr_i,
    .core_sleep_i, .cpu_pwr_off_en_i,
    .intr_o, .fast_intr_o,
    .cpu_off_req_o(cpu_off_req)
  );

  pwr_gate_seq cpu_seq (
    .clk_i, .reset_i,
    .off_req_i     (cpu_off_req),
    .pwrgate_ack_ni(cpu_pwrgate_ack_ni),
    .clkgate_en_no (cpu_clkgate_en_no),
    .iso_en_no     (cpu_iso_no),
    .rst_no        (cpu_seq_rst_n),
    .pwrgate_en_no (cpu_pwrgate_switch_no)
  );

  pwr_gate_seq periph_seq (
    .clk_i, .reset_i,
    .off_req_i     (periph_pwr_off_req_i),
    .pwrgate_ack_ni(periph_pwrgate_ack_ni),
    .clkgate_en_no (periph_clkgate_en_no),
    .iso_en_no     (periph_iso_no),
    .rst_no        (periph_seq_rst_n),
    .pwrgate_en_no (periph_pwrgate_switch_no)
  );

  // banks keep retention only, no switch
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    mem_retention_seq bank_seq (
      .clk_i, .reset_i,
      .retain_req_i    (mem_retain_req_i[b]),
      .clkgate_en_no   (mem_clkgate_en_no[b]),
      .set_retentive_no(mem_set_retentive_no[b])
    );
  end

  domain_reset_gen rst_gen (
    .clk_i, .reset_i, .debug_ndmreset_ni,
    .cpu_seq_rst_ni   (cpu_seq_rst_n),
    .periph_seq_rst_ni(periph_seq_rst_n),
    .sys_rst_no, .cpu_rst_no, .periph_rst_no
  );

endmodule

`default_nettype wire

/* design/mem_retention_seq.sv */
// ------------------------------
// retention entry and exit for one memory bank
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_retention_seq
  import mcu_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic retain_req_i,
  output logic clkgate_en_no,
  output logic set_retentive_no
);

  mem_ret_state_t state_q;
  mem_ret_state_t state_d;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= MR_ACTIVE;
    end else begin
      state_q <= state_d;
    end
  end

  // CLK_OFF is shared by entry and exit, the request picks the way out
  always_comb begin
    state_d = state_q;
    case (state_q)
      MR_ACTIVE: begin
        if (retain_req_i) begin
          state_d = MR_CLK_OFF;
        end
      end
      MR_CLK_OFF: state_d = retain_req_i ? MR_RETAIN : MR_ACTIVE;
      MR_RETAIN: begin
        if (!retain_req_i) begin
          state_d = MR_CLK_OFF;
        end
      end
      default: state_d = MR_ACTIVE;
    endcase
  end

  // bank clock stays gated around every retention change
  assign clkgate_en_no    = (state_q == MR_ACTIVE);
  assign set_retentive_no = (state_q != MR_RETAIN);

endmodule

`default_nettype wire

/* design/pwr_gate_seq.sv */
// ------------------------------
// power-down and power-up sequencer
// for one switched domain
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module pwr_gate_seq
  import mcu_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic off_req_i,
  input  logic pwrgate_ack_ni,
  output logic clkgate_en_no,
  output logic iso_en_no,
  output logic rst_no,
  output logic pwrgate_en_no
);

  pwr_gate_state_t state_q;
  pwr_gate_state_t state_d;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= PG_ON;
    end else begin
      state_q <= state_d;
    end
  end

  // requests are only looked at in ON and OFF
  always_comb begin
    state_d = state_q;
    case (state_q)
      PG_ON: begin
        if (off_req_i) begin
          state_d = PG_CLK_OFF;
        end
      end
      PG_CLK_OFF: state_d = PG_ISO_ON;
      PG_ISO_ON:  state_d = PG_RST_ON;
      PG_RST_ON:  state_d = PG_SW_OFF;
      PG_SW_OFF: begin
        // switch reports open
        if (pwrgate_ack_ni) begin
          state_d = PG_OFF;
        end
      end
      PG_OFF: begin
        if (!off_req_i) begin
          state_d = PG_SW_ON;
        end
      end
      PG_SW_ON: begin
        // wait for the rail to be back
        if (!pwrgate_ack_ni) begin
          state_d = PG_RST_OFF;
        end
      end
      PG_RST_OFF: state_d = PG_ISO_OFF;
      PG_ISO_OFF: state_d = PG_ON;
      default:    state_d = PG_ON;
    endcase
  end

  // all outputs active low, decoded from the state register
  always_comb begin
    clkgate_en_no = 1'b0;
    iso_en_no     = 1'b0;
    rst_no        = 1'b0;
    pwrgate_en_no = 1'b1;
    case (state_q)
      PG_ON: begin
        clkgate_en_no = 1'b1;
        iso_en_no     = 1'b1;
        rst_no        = 1'b1;
      end
      PG_CLK_OFF: begin
        iso_en_no = 1'b1;
        rst_no    = 1'b1;
      end
      PG_ISO_ON: begin
        rst_no = 1'b1;
      end
      PG_SW_OFF,
      PG_OFF: begin
        pwrgate_en_no = 1'b0;
      end
      PG_RST_OFF: begin
        rst_no = 1'b1;
      end
      PG_ISO_OFF: begin
        iso_en_no = 1'b1;
        rst_no    = 1'b1;
      end
      default: begin
        // RST_ON and SW_ON keep the defaults
        pwrgate_en_no = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* sim.f */
design/mcu_ctrl_pkg.sv
design/irq_wakeup_ctrl.sv
design/pwr_gate_seq.sv
design/mem_retention_seq.sv
design/domain_reset_gen.sv
design/mcu_pwr_irq_top.sv
sim/tb_mcu_pwr_irq.sv

/* sim/irq_patterns.txt */
// columns: ctrl {ext, sw, spi_flash, spi, dma, timer[3:0]}, gpio_ao,
// expected intr_o, expected fast_intr_o
000 00 00000000 0000
001 00 00000080 0000
002 00 00010000 0001
004 00 00020000 0002
008 00 00040000 0004
010 00 00080000 0008
020 00 00100000 0010
040 00 00200000 0020
080 00 00000008 0000
100 00 00000800 0000
000 01 00400000 0040
000 80 20000000 2000
000 ff 3fc00000 3fc0
000 a5 29400000 2940
00f 00 00070080 0007
070 00 00380000 0038
180 00 00000808 0000
1ff ff 3fff0888 3fff
0aa 00 00150008 0015
155 5a 16aa0880 16aa
003 02 00810080 0081
0c0 40 10200008 1020
101 10 04000880 0400
018 00 000c0000 000c
024 08 02120000 0212
1fe 7f 1fff0808 1fff
0ff 00 003f0088 003f
000 00 00000000 0000

/* sim/tb_mcu_pwr_irq.sv */
// ------------------------------
// testbench for the power and interrupt control slice
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_mcu_pwr_irq
  import mcu_ctrl_pkg::*;
;

  localparam int    CLK_PERIOD      = 100;
  localparam int    DRIVE_DELAY     = 10;
  localparam int    NUM_PATTERNS    = 28;
  localparam int    NUM_SEQ_TESTS   = 5;
  localparam int    SEQ_TEST_CYCLES = 40;
  localparam int    TIMEOUT_CYCLES  = (NUM_PATTERNS + SEQ_TEST_CYCLES * NUM_SEQ_TESTS) * 2;
  localparam string PATTERN_FILE    = "sim/irq_patterns.txt";

  logic clk_i, reset_i;
  timer_intr_t timer_intr_i;
  logic dma_done_intr_i, spi_intr_i, spi_flash_intr_i, irq_software_i, irq_external_i;
  gpio_ao_intr_t gpio_ao_intr_i;
  logic core_sleep_i, cpu_pwr_off_en_i, periph_pwr_off_req_i, debug_ndmreset_ni;
  bank_mask_t mem_retain_req_i;
  logic cpu_pwrgate_ack_ni, periph_pwrgate_ack_ni;
  intr_vec_t intr_o;
  fast_intr_t fast_intr_o;
  logic cpu_clkgate_en_no, cpu_iso_no, cpu_pwrgate_switch_no, cpu_rst_no;
  logic periph_clkgate_en_no, periph_iso_no, periph_pwrgate_switch_no, periph_rst_no;
  logic sys_rst_no;
  bank_mask_t mem_clkgate_en_no, mem_set_retentive_no;

  // domain groups hold clock gate, isolation, reset and switch from msb down
  logic [31:0] cpu_ctrl, periph_ctrl, mem_ctrl, rst_ctrl;
  logic [31:0] pattern_mem [0:NUM_PATTERNS*4-1];
  int periph_ack_delay = 0;
  int cycle_count = 0;

  assign cpu_ctrl    = {28'b0, cpu_clkgate_en_no, cpu_iso_no, cpu_rst_no, cpu_pwrgate_switch_no};
  assign periph_ctrl = {28'b0, periph_clkgate_en_no, periph_iso_no, periph_rst_no,
                        periph_pwrgate_switch_no};
  assign mem_ctrl    = {28'b0, mem_clkgate_en_no, mem_set_retentive_no};
  assign rst_ctrl    = {29'b0, sys_rst_no, cpu_rst_no, periph_rst_no};

  mcu_pwr_irq_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("TEST FAILED");
      $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  function automatic int pick_ack_delay(input int fixed_cycles);
    if (fixed_cycles > 0) begin
      return fixed_cycles;
    end else begin
      return int'($urandom_range(8, 1));
    end
  endfunction

  // switch models drive ack_ni to the inverse of en_no after a delay
  initial begin
    int delay_cycles;
    logic target_n;
    cpu_pwrgate_ack_ni = 1'b0;
    forever begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (cpu_pwrgate_ack_ni !== ~cpu_pwrgate_switch_no) begin
        target_n = ~cpu_pwrgate_switch_no;
        delay_cycles = pick_ack_delay(0);
        repeat (delay_cycles) @(posedge clk_i);
        #DRIVE_DELAY;
        cpu_pwrgate_ack_ni = target_n;
      end
    end
  end

  initial begin
    int delay_cycles;
    logic target_n;
    periph_pwrgate_ack_ni = 1'b0;
    forever begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (periph_pwrgate_ack_ni !== ~periph_pwrgate_switch_no) begin
        target_n = ~periph_pwrgate_switch_no;
        delay_cycles = pick_ack_delay(periph_ack_delay);
        repeat (delay_cycles) @(posedge clk_i);
        #DRIVE_DELAY;
        periph_pwrgate_ack_ni = target_n;
      end
    end
  end

  task check_value(input string test_name, input logic [31:0] expected,
                   input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "wrong value in %s", test_name);
    end
  endtask

  task load_patterns();
    int fd;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("TEST FAILED");
      $fatal(1, "cannot open the pattern file %s", PATTERN_FILE);
    end else begin
      $fclose(fd);
      $readmemh(PATTERN_FILE, pattern_mem);
    end
  endtask

  task drive_edge();
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // sample at the falling edge after the next rising edge
  task sample_after_edge();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  function automatic logic [31:0] domain_ctrl(input int dom);
    return (dom == 0) ? cpu_ctrl : periph_ctrl;
  endfunction

  function automatic logic domain_ack(input int dom);
    return (dom == 0) ? cpu_pwrgate_ack_ni : periph_pwrgate_ack_ni;
  endfunction

  task check_power_down(input int dom, input string name);
    @(negedge clk_i);
    check_value({name, " idle"}, 32'b1111, domain_ctrl(dom));
    sample_after_edge();
    check_value({name, " clock gate"}, 32'b0111, domain_ctrl(dom));
    sample_after_edge();
    check_value({name, " isolation"}, 32'b0011, domain_ctrl(dom));
    sample_after_edge();
    check_value({name, " sequencer reset"}, 32'b0011, domain_ctrl(dom));
    sample_after_edge();
    check_value({name, " switch off"}, 32'b0000, domain_ctrl(dom));
    while (domain_ack(dom) !== 1'b1) begin
      sample_after_edge();
      check_value({name, " ack wait"}, 32'b0000, domain_ctrl(dom));
    end
    sample_after_edge();
    check_value({name, " off"}, 32'b0000, domain_ctrl(dom));
  endtask

  task check_power_up(input int dom, input string name);
    @(negedge clk_i);
    check_value({name, " request"}, 32'b0000, domain_ctrl(dom));
    sample_after_edge();
    check_value({name, " switch on"}, 32'b0001, domain_ctrl(dom));
    while (domain_ack(dom) !== 1'b0) begin
      sample_after_edge();
      check_value({name, " ack wait"}, 32'b0001, domain_ctrl(dom));
    end
    sample_after_edge();
    check_value({name, " sequencer reset release"}, 32'b0001, domain_ctrl(dom));
    sample_after_edge();
    check_value({name, " reset and isolation"}, 32'b0111, domain_ctrl(dom));
    sample_after_edge();
    check_value({name, " clock on"}, 32'b1111, domain_ctrl(dom));
  endtask

  initial begin
    int i;
    logic [31:0] ctrl;
    void'($urandom(32'h184f_afc3));
    reset_i = 1'b1;
    timer_intr_i = '0;
    dma_done_intr_i = 1'b0;
    spi_intr_i = 1'b0;
    spi_flash_intr_i = 1'b0;
    irq_software_i = 1'b0;
    irq_external_i = 1'b0;
    gpio_ao_intr_i = '0;
    core_sleep_i = 1'b0;
    cpu_pwr_off_en_i = 1'b0;
    periph_pwr_off_req_i = 1'b0;
    mem_retain_req_i = '0;
    debug_ndmreset_ni = 1'b1;
    load_patterns();
    repeat (2) @(posedge clk_i);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    sample_after_edge();
    check_value("reset cpu", 32'b1111, cpu_ctrl);
    check_value("reset periph", 32'b1111, periph_ctrl);
    check_value("reset banks", 32'b1111, mem_ctrl);
    check_value("reset outputs", 32'b111, rst_ctrl);

    for (i = 0; i < NUM_PATTERNS; i++) begin
      drive_edge();
      ctrl = pattern_mem[4*i];
      timer_intr_i     = ctrl[3:0];
      dma_done_intr_i  = ctrl[4];
      spi_intr_i       = ctrl[5];
      spi_flash_intr_i = ctrl[6];
      irq_software_i   = ctrl[7];
      irq_external_i   = ctrl[8];
      gpio_ao_intr_i   = pattern_mem[4*i+1][7:0];
      sample_after_edge();
      check_value($sformatf("pattern %0d intr", i), pattern_mem[4*i+2], intr_o);
      check_value($sformatf("pattern %0d fast", i), pattern_mem[4*i+3], {17'b0, fast_intr_o});
    end

    // core sleeps with nothing pending
    drive_edge();
    core_sleep_i = 1'b1;
    cpu_pwr_off_en_i = 1'b1;
    check_power_down(0, "cpu sleep");
    drive_edge();
    irq_external_i = 1'b1;
    check_power_up(0, "cpu wake");
    drive_edge();
    irq_external_i = 1'b0;
    core_sleep_i = 1'b0;
    cpu_pwr_off_en_i = 1'b0;

    periph_ack_delay = 8;
    drive_edge();
    periph_pwr_off_req_i = 1'b1;
    check_power_down(1, "periph off");
    drive_edge();
    periph_pwr_off_req_i = 1'b0;
    check_power_up(1, "periph on");

    drive_edge();
    mem_retain_req_i = 2'b01;
    @(negedge clk_i);
    check_value("bank0 enter idle", 32'b1111, mem_ctrl);
    sample_after_edge();
    check_value("bank0 clock gate", 32'b1011, mem_ctrl);
    sample_after_edge();
    check_value("bank0 retentive", 32'b1010, mem_ctrl);
    sample_after_edge();
    check_value("bank0 retain hold", 32'b1010, mem_ctrl);
    drive_edge();
    mem_retain_req_i = 2'b00;
    @(negedge clk_i);
    check_value("bank0 exit request", 32'b1010, mem_ctrl);
    sample_after_edge();
    check_value("bank0 leave retention", 32'b1011, mem_ctrl);
    sample_after_edge();
    check_value("bank0 clock on", 32'b1111, mem_ctrl);

    drive_edge();
    debug_ndmreset_ni = 1'b0;
    drive_edge();
    debug_ndmreset_ni = 1'b1;
    @(negedge clk_i);
    check_value("debug reset low", 32'b000, rst_ctrl);
    sample_after_edge();
    check_value("debug reset release", 32'b111, rst_ctrl);
    check_value("debug cpu on", 32'b1111, cpu_ctrl);
    check_value("debug periph on", 32'b1111, periph_ctrl);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
